/* common/ohci_ed_pkg.sv */
package ohci_ed_pkg;

    // ed layout, four dwords per endpoint descriptor
    localparam int unsigned EdWords = 4;

    // dword index inside an ed
    localparam int unsigned DwStatus = 0; // mps, f, k, s, d, en, fa
    localparam int unsigned DwTail   = 1; // tail td pointer
    localparam int unsigned DwHead   = 2; // head td pointer, c, h
    localparam int unsigned DwNext   = 3; // next ed pointer

    // 16 byte aligned pointers live in 31:4
    localparam int unsigned AddrMsb = 31;
    localparam int unsigned AddrLsb = 4;

    // dword0 field positions
    localparam int unsigned MpsMsb = 26;
    localparam int unsigned MpsLsb = 16;
    localparam int unsigned FBit   = 15; // format, iso td
    localparam int unsigned KBit   = 14; // skip
    localparam int unsigned SBit   = 13; // low speed
    localparam int unsigned DMsb   = 12;
    localparam int unsigned DLsb   = 11;
    localparam int unsigned EnMsb  = 10;
    localparam int unsigned EnLsb  = 7;
    localparam int unsigned FaMsb  = 6;
    localparam int unsigned FaLsb  = 0;

    // dword2 flag bits
    localparam int unsigned CBit = 1; // toggle carry
    localparam int unsigned HBit = 0; // halted

    typedef logic [31:0]              ed_word_t;
    typedef logic [AddrMsb:AddrLsb]   ed_addr_t;
    typedef logic [MpsMsb-MpsLsb:0]   ed_mps_t;
    typedef logic [FaMsb-FaLsb:0]     ed_fa_t;
    typedef logic [EnMsb-EnLsb:0]     ed_en_t;
    typedef logic [DMsb-DLsb:0]       ed_dir_t;

    // list walker fsm
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        WAIT_LOAD,
        HALT
    } walker_state_t;

    // pointer part of a dword
    function automatic ed_addr_t ed_ptr(input ed_word_t word);
        return word[AddrMsb:AddrLsb];
    endfunction

endpackage

/* dma_queue/ed_register_chain.sv */
`timescale 1ns/100ps

// shift chain, stage 0 takes the newest word, stage Stages-1 holds the oldest
module ed_register_chain #(
    parameter int unsigned Width  = 32,
    parameter int unsigned Stages = 4
)(
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           clear_i,  // sync clear of every stage
    input  logic                           en_i,     // one shift per accepted word
    input  logic [Width-1:0]               data_i,
    output logic [Stages-1:0][Width-1:0]   chain_o
);

    always_ff @(posedge clk_i) begin
        if (reset_i || clear_i) begin
            chain_o <= '0;
        end else if (en_i) begin
            chain_o[0] <= data_i; // newest word enters here
            for (int unsigned i = 1; i < Stages; i++) begin
                chain_o[i] <= chain_o[i-1]; // oldest drops off the far end
            end
        end
    end

endmodule

/* dma_queue/ed_output_queue.sv */
`timescale 1ns/100ps

// two stage ed queue: secondin loads from the read stream, firstin feeds td processing
// stash keeps a nonperiodic ed alive across a periodic detour
module ed_output_queue #(
    parameter int unsigned AxiDataWidth         = 32,
    parameter int unsigned DmaOutputQueueStages = 4
)(
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  logic                     pop_i,                 // move secondin or stash into firstin
    input  logic                     context_switch_np2p_i, // nonperiodic to periodic
    input  logic                     context_switch_p2np_i, // periodic to nonperiodic
    input  logic [AxiDataWidth-1:0]  dma_data_i,
    input  logic                     dma_valid_i,
    output logic                     dma_ready_o,
    output logic                     secondin_loaded_o,
    output logic                     secondin_empty_o,      // loaded but no tds
    output logic                     secondin_valid_o,      // loaded and has tds
    output ohci_ed_pkg::ed_addr_t    secondin_next_o,
    output logic                     pop_ready_o,
    output logic                     firstin_valid_o,
    output ohci_ed_pkg::ed_word_t    firstin_dword0_o,
    output ohci_ed_pkg::ed_word_t    firstin_dword1_o,
    output ohci_ed_pkg::ed_word_t    firstin_dword2_o,
    output ohci_ed_pkg::ed_word_t    firstin_dword3_o
);

    localparam int unsigned EdWords = ohci_ed_pkg::EdWords;
    localparam int unsigned WordW   = $bits(ohci_ed_pkg::ed_word_t);

    logic [DmaOutputQueueStages-1:0][AxiDataWidth-1:0] word_chain;
    logic [DmaOutputQueueStages-1:0][0:0]              fill_chain;

    ohci_ed_pkg::ed_word_t secondin_w [EdWords]; // dword k of the loaded ed
    ohci_ed_pkg::ed_word_t stash_q    [EdWords];
    ohci_ed_pkg::ed_word_t sel_w      [EdWords]; // stash or secondin, whichever pops
    ohci_ed_pkg::ed_word_t firstin_q  [EdWords];

    ohci_ed_pkg::ed_addr_t tail_ptr;
    ohci_ed_pkg::ed_addr_t head_ptr;

    logic dma_en;        // word accepted this cycle
    logic loaded;
    logic no_td;
    logic clear_fill;
    logic pop_accept;
    logic pop_stash;     // this pop drains the stash
    logic pop_secondin;  // this pop drains secondin
    logic stash_take;    // np2p with a valid secondin
    logic stash_active_q;
    logic stash_release_q; // back on nonperiodic, stash may pop
    logic firstin_valid_q;

    assign dma_en      = dma_valid_i && dma_ready_o;
    assign dma_ready_o = !loaded; // back-pressure while secondin is full

    // ed words, shifted in dword0 first
    ed_register_chain #(
        .Width  (AxiDataWidth),
        .Stages (DmaOutputQueueStages)
    ) i_word_chain (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .clear_i (1'b0),       // payload stays, only the fill flags are dropped
        .en_i    (dma_en),
        .data_i  (dma_data_i),
        .chain_o (word_chain)
    );

    // ones walk along with the words, last stage set means all words in
    ed_register_chain #(
        .Width  (1),
        .Stages (DmaOutputQueueStages)
    ) i_fill_chain (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .clear_i (clear_fill),
        .en_i    (dma_en),
        .data_i  (1'b1),
        .chain_o (fill_chain)
    );

    // oldest stage holds dword0
    for (genvar k = 0; k < EdWords; k++) begin : g_unpack
        assign secondin_w[k] = word_chain[DmaOutputQueueStages-1-k][WordW-1:0];
    end

    assign tail_ptr = ohci_ed_pkg::ed_ptr(secondin_w[ohci_ed_pkg::DwTail]);
    assign head_ptr = ohci_ed_pkg::ed_ptr(secondin_w[ohci_ed_pkg::DwHead]);
    assign no_td    = (tail_ptr == head_ptr); // tail equals head, nothing queued

    assign loaded            = fill_chain[DmaOutputQueueStages-1][0];
    assign secondin_loaded_o = loaded;
    assign secondin_empty_o  = loaded && no_td;
    assign secondin_valid_o  = loaded && !no_td;
    assign secondin_next_o   = ohci_ed_pkg::ed_ptr(secondin_w[ohci_ed_pkg::DwNext]);

    // pop handshake, stash has priority once released
    assign pop_ready_o  = secondin_valid_o || stash_release_q;
    assign pop_accept   = pop_i && pop_ready_o;
    assign pop_stash    = pop_accept && stash_release_q;
    assign pop_secondin = pop_accept && !stash_release_q;

    // empty ed drops after one cycle so the walker can follow its link
    assign clear_fill = pop_secondin || secondin_empty_o
                        || context_switch_np2p_i || context_switch_p2np_i;

    assign stash_take = context_switch_np2p_i && secondin_valid_o;

    // stash flags
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            stash_active_q  <= 1'b0;
            stash_release_q <= 1'b0;
        end else begin
            if (stash_take) begin
                stash_active_q <= 1'b1;
            end else if (pop_stash) begin
                stash_active_q <= 1'b0;
            end
            if (context_switch_p2np_i && stash_active_q) begin
                stash_release_q <= 1'b1; // next pop comes from the stash
            end else if (pop_stash) begin
                stash_release_q <= 1'b0;
            end
        end
    end

    // stash payload
    always_ff @(posedge clk_i) begin
        if (stash_take) begin
            stash_q <= secondin_w;
        end
    end

    always_comb begin
        for (int unsigned k = 0; k < EdWords; k++) begin
            sel_w[k] = stash_release_q ? stash_q[k] : secondin_w[k];
        end
    end

    // firstin register
    always_ff @(posedge clk_i) begin
        if (pop_accept) begin
            firstin_q <= sel_w;
        end else if (secondin_empty_o) begin
            // skipped ed, keep the list link of firstin current
            firstin_q[ohci_ed_pkg::DwNext][ohci_ed_pkg::AddrMsb:ohci_ed_pkg::AddrLsb]
                <= secondin_next_o;
        end
    end

    // valid from the first pop until reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            firstin_valid_q <= 1'b0;
        end else if (pop_accept) begin
            firstin_valid_q <= 1'b1;
        end
    end

    assign firstin_valid_o  = firstin_valid_q;
    assign firstin_dword0_o = firstin_q[ohci_ed_pkg::DwStatus];
    assign firstin_dword1_o = firstin_q[ohci_ed_pkg::DwTail];
    assign firstin_dword2_o = firstin_q[ohci_ed_pkg::DwHead];
    assign firstin_dword3_o = firstin_q[ohci_ed_pkg::DwNext];

endmodule

/* verilog/ed_list_walker.sv */
`timescale 1ns/100ps

// walks the periodic and nonperiodic ed lists, one fetch request per ed
module ed_list_walker (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  ohci_ed_pkg::ed_addr_t periodic_head_i,
    input  ohci_ed_pkg::ed_addr_t nonperiodic_head_i,
    input  logic                  context_switch_np2p_i,
    input  logic                  context_switch_p2np_i,
    input  logic                  secondin_loaded_i,
    input  ohci_ed_pkg::ed_addr_t secondin_next_i,
    output logic                  fetch_req_o,  // one cycle pulse
    output ohci_ed_pkg::ed_addr_t fetch_addr_o  // stable until the next request
);

    ohci_ed_pkg::walker_state_t state_q, state_d;

    ohci_ed_pkg::ed_addr_t np_ptr_q, np_ptr_d; // nonperiodic position, kept over detours
    ohci_ed_pkg::ed_addr_t p_ptr_q, p_ptr_d;
    ohci_ed_pkg::ed_addr_t cur_ptr_d;          // pointer of the list active next cycle
    ohci_ed_pkg::ed_addr_t fetch_addr_q;

    logic periodic_q, periodic_d; // active list
    logic loaded_q;               // for the falling edge of the fill flag

    always_comb begin
        state_d    = state_q;
        periodic_d = periodic_q;
        np_ptr_d   = np_ptr_q;
        p_ptr_d    = p_ptr_q;

        // follow the link of the ed that just loaded
        if (state_q == ohci_ed_pkg::WAIT_LOAD && secondin_loaded_i) begin
            if (periodic_q) begin
                p_ptr_d = secondin_next_i;
            end else begin
                np_ptr_d = secondin_next_i;
            end
        end

        case (state_q)
            ohci_ed_pkg::IDLE: begin
                np_ptr_d = nonperiodic_head_i; // walk starts on nonperiodic
                state_d  = ohci_ed_pkg::FETCH;
            end
            ohci_ed_pkg::FETCH: begin
                state_d = ohci_ed_pkg::WAIT_LOAD;
            end
            ohci_ed_pkg::WAIT_LOAD: begin
                if (loaded_q && !secondin_loaded_i) begin
                    state_d = ohci_ed_pkg::FETCH; // queue freed secondin
                end
            end
            default: begin
                state_d = state_q; // halt until a switch
            end
        endcase

        // a context switch restarts the walk on the other list
        if (context_switch_np2p_i) begin
            periodic_d = 1'b1;
            p_ptr_d    = periodic_head_i;
            state_d    = ohci_ed_pkg::FETCH;
        end else if (context_switch_p2np_i) begin
            periodic_d = 1'b0; // resume saved np pointer
            state_d    = ohci_ed_pkg::FETCH;
        end

        cur_ptr_d = periodic_d ? p_ptr_d : np_ptr_d;

        // end of list
        if (state_d == ohci_ed_pkg::FETCH && cur_ptr_d == '0) begin
            state_d = ohci_ed_pkg::HALT;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q      <= ohci_ed_pkg::IDLE;
            periodic_q   <= 1'b0;
            np_ptr_q     <= '0;
            p_ptr_q      <= '0;
            fetch_addr_q <= '0;
            loaded_q     <= 1'b0;
        end else begin
            state_q    <= state_d;
            periodic_q <= periodic_d;
            np_ptr_q   <= np_ptr_d;
            p_ptr_q    <= p_ptr_d;
            loaded_q   <= secondin_loaded_i;
            if (state_d == ohci_ed_pkg::FETCH) begin
                fetch_addr_q <= cur_ptr_d; // latched with the request
            end
        end
    end

    assign fetch_req_o  = (state_q == ohci_ed_pkg::FETCH);
    assign fetch_addr_o = fetch_addr_q;

endmodule

/* verilog/ohci_ed_fetch_top.sv */
`timescale 1ns/100ps

// ed fetch path: list walker plus two stage output queue
module ohci_ed_fetch_top #(
    parameter int unsigned AxiDataWidth         = 32,
    parameter int unsigned DmaOutputQueueStages = 4
)(
    input  logic                     clk_i,
    input  logic                     reset_i,
    // list heads from the register file
    input  ohci_ed_pkg::ed_addr_t    periodic_head_i,
    input  ohci_ed_pkg::ed_addr_t    nonperiodic_head_i,
    input  logic                     context_switch_np2p_i,
    input  logic                     context_switch_p2np_i,
    // fetch requests
    output logic                     fetch_req_o,
    output ohci_ed_pkg::ed_addr_t    fetch_addr_o,
    // read data stream
    input  logic [AxiDataWidth-1:0]  dma_data_i,
    input  logic                     dma_valid_i,
    output logic                     dma_ready_o,
    // queue status
    output logic                     secondin_loaded_o,
    output logic                     secondin_empty_o,
    output logic                     secondin_valid_o,
    // firstin toward td processing
    input  logic                     pop_i,
    output logic                     pop_ready_o,
    output logic                     firstin_valid_o,
    output ohci_ed_pkg::ed_word_t    firstin_dword0_o,
    output ohci_ed_pkg::ed_word_t    firstin_dword1_o,
    output ohci_ed_pkg::ed_word_t    firstin_dword2_o,
    output ohci_ed_pkg::ed_word_t    firstin_dword3_o
);

    ohci_ed_pkg::ed_addr_t secondin_next; // link of the loaded ed

    ed_list_walker i_walker (
        .clk_i                 (clk_i),
        .reset_i               (reset_i),
        .periodic_head_i       (periodic_head_i),
        .nonperiodic_head_i    (nonperiodic_head_i),
        .context_switch_np2p_i (context_switch_np2p_i),
        .context_switch_p2np_i (context_switch_p2np_i),
        .secondin_loaded_i     (secondin_loaded_o),
        .secondin_next_i       (secondin_next),
        .fetch_req_o           (fetch_req_o),
        .fetch_addr_o          (fetch_addr_o)
    );

    ed_output_queue #(
        .AxiDataWidth         (AxiDataWidth),
        .DmaOutputQueueStages (DmaOutputQueueStages)
    ) i_queue (
        .clk_i                 (clk_i),
        .reset_i               (reset_i),
        .pop_i                 (pop_i),
        .context_switch_np2p_i (context_switch_np2p_i),
        .context_switch_p2np_i (context_switch_p2np_i),
        .dma_data_i            (dma_data_i),
        .dma_valid_i           (dma_valid_i),
        .dma_ready_o           (dma_ready_o),
        .secondin_loaded_o     (secondin_loaded_o),
        .secondin_empty_o      (secondin_empty_o),
        .secondin_valid_o      (secondin_valid_o),
        .secondin_next_o       (secondin_next),
        .pop_ready_o           (pop_ready_o),
        .firstin_valid_o       (firstin_valid_o),
        .firstin_dword0_o      (firstin_dword0_o),
        .firstin_dword1_o      (firstin_dword1_o),
        .firstin_dword2_o      (firstin_dword2_o),
        .firstin_dword3_o      (firstin_dword3_o)
    );

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/100ps

// free running clock, reset held over the first edges
module tb_clock_gen #(
    parameter int unsigned HalfPeriod  = 2, // ns, 4 ns period
    parameter int unsigned ResetCycles = 3
)(
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HalfPeriod) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (ResetCycles) @(posedge clk_o);
        #1 reset_o = 1'b0; // released off the edge like all stimulus
    end

endmodule

/* sim/ed_queue_chk.sv */
`timescale 1ns/100ps

// handshake rules of the ed output queue
module ed_queue_chk (
    input logic clk_i,
    input logic reset_i,
    input logic pop_i,
    input logic dma_valid_i,
    input logic dma_ready_i,
    input logic loaded_i,
    input logic pop_ready_i,
    input logic firstin_valid_i
);

    int unsigned err_count = 0; // failed assertions so far

    // secondin fills only through an accepted stream word
    a_load_on_word : assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(loaded_i) |-> $past(dma_valid_i && dma_ready_i))
        else begin
            err_count++;
            $error("secondin became loaded without an accepted stream word");
        end

    a_valid_sticky : assert property (@(posedge clk_i) disable iff (reset_i)
        firstin_valid_i |=> firstin_valid_i) // once set, held until reset
        else begin
            err_count++;
            $error("firstin valid fell without reset");
        end

    a_pop_ready : assert property (@(posedge clk_i) disable iff (reset_i)
        pop_i |-> pop_ready_i)
        else begin
            err_count++;
            $error("pop driven while the queue has nothing to pop");
        end

endmodule

bind ed_output_queue ed_queue_chk i_chk (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .pop_i           (pop_i),
    .dma_valid_i     (dma_valid_i),
    .dma_ready_i     (dma_ready_o),
    .loaded_i        (secondin_loaded_o),
    .pop_ready_i     (pop_ready_o),
    .firstin_valid_i (firstin_valid_o)
);

/* sim/tb_ohci_ed_fetch.sv */
`timescale 1ns/100ps

module tb_ohci_ed_fetch;

    typedef logic [3:0][31:0] ed_image_t; // dword k at index k

    localparam ohci_ed_pkg::ed_addr_t NpHead = 28'h0001000;
    localparam ohci_ed_pkg::ed_addr_t PHead  = 28'h0004000;

    logic clk_w;
    logic reset_w;
    logic pop;
    logic np2p;
    logic p2np;
    logic dma_valid;
    logic dma_ready;
    logic fetch_req;
    logic loaded;
    logic sec_empty;
    logic sec_valid;
    logic pop_ready;
    logic fi_valid;
    logic [31:0] dma_data;
    ohci_ed_pkg::ed_addr_t fetch_addr;
    ohci_ed_pkg::ed_word_t fi_w [4];

    ed_image_t ed_mem [ohci_ed_pkg::ed_addr_t]; // ed memory keyed by pointer
    ohci_ed_pkg::ed_addr_t exp_q [$];           // popped eds waiting for compare
    ohci_ed_pkg::ed_addr_t ref_link;            // expected next-ED field of firstin
    ohci_ed_pkg::ed_addr_t fetch_exp = NpHead;  // address of the next fetch request
    logic [31:0] rng_build = 32'h5943;
    logic [31:0] rng_resp;
    logic [31:0] rng_pop;
    int unsigned ref_visits = 0; // eds the reference walk has touched
    int unsigned served = 0;     // eds fully returned by the responder
    int unsigned n_np;
    int unsigned n_p;
    logic lists_built = 1'b0;

    tb_clock_gen i_clk_gen (.clk_o(clk_w), .reset_o(reset_w));

    ohci_ed_fetch_top #(
        .AxiDataWidth         (32),
        .DmaOutputQueueStages (ohci_ed_pkg::EdWords)
    ) uut (
        .clk_i (clk_w), .reset_i (reset_w),
        .periodic_head_i (PHead), .nonperiodic_head_i (NpHead),
        .context_switch_np2p_i (np2p), .context_switch_p2np_i (p2np),
        .fetch_req_o (fetch_req), .fetch_addr_o (fetch_addr),
        .dma_data_i (dma_data), .dma_valid_i (dma_valid), .dma_ready_o (dma_ready),
        .secondin_loaded_o (loaded), .secondin_empty_o (sec_empty),
        .secondin_valid_o (sec_valid), .pop_i (pop), .pop_ready_o (pop_ready),
        .firstin_valid_o (fi_valid),
        .firstin_dword0_o (fi_w[0]), .firstin_dword1_o (fi_w[1]),
        .firstin_dword2_o (fi_w[2]), .firstin_dword3_o (fi_w[3])
    );

    function automatic logic [31:0] xorshift(inout logic [31:0] state);
        state ^= state << 13;
        state ^= state >> 17;
        state ^= state << 5;
        return state;
    endfunction

    function automatic logic is_empty(input ohci_ed_pkg::ed_addr_t addr);
        return ed_mem[addr][1][31:4] == ed_mem[addr][2][31:4]; // tail equals head
    endfunction

    // reference walk, first non-empty ed from start on
    function automatic ohci_ed_pkg::ed_addr_t ref_next_ed(input ohci_ed_pkg::ed_addr_t start);
        ohci_ed_pkg::ed_addr_t cur;
        cur = start;
        ref_visits++;
        while (cur != '0 && is_empty(cur)) begin
            ref_link = ed_mem[cur][3][31:4]; // skipped ed rewrites the firstin link
            cur = ref_link;
            ref_visits++;
        end
        return cur;
    endfunction

    function automatic int unsigned count_nonempty(input ohci_ed_pkg::ed_addr_t head);
        ohci_ed_pkg::ed_addr_t cur;
        int unsigned n;
        cur = head;
        n = 0;
        while (cur != '0) begin
            n += is_empty(cur) ? 0 : 1;
            cur = ed_mem[cur][3][31:4];
        end
        return n;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run("value check failed");
        end
    endtask

    // linked list of len eds, random empties, keep_ends forces first and last non-empty
    task automatic build_list(input ohci_ed_pkg::ed_addr_t head, input int unsigned len,
                              input logic keep_ends);
        ohci_ed_pkg::ed_addr_t addr;
        ohci_ed_pkg::ed_addr_t nxt;
        logic [31:0] r;
        logic [31:0] t;
        logic empty;
        addr = head;
        for (int unsigned i = 0; i < len; i++) begin
            r = xorshift(rng_build);
            t = xorshift(rng_build);
            nxt = (i == len - 1) ? '0 : addr + 1 + r[1:0];
            empty = (r[4:3] == 2'b00) && !(keep_ends && (i == 0 || i == len - 1));
            ed_mem[addr] = {{nxt, r[19:16]},                                   // dword3
                            {(empty ? t[31:4] : t[31:4] + 28'd1 + r[9:6]), 2'b00, r[15:14]},
                            {t[31:4], r[13:10]},                                // tail
                            xorshift(rng_build) & 32'h07ff_ffff};               // dword0
            addr = nxt;
        end
    endtask

    // four words in order, random valid gaps, data held under back-pressure
    task automatic serve_ed(input ohci_ed_pkg::ed_addr_t addr);
        logic [31:0] r;
        for (int unsigned w = 0; w < 4; w++) begin
            r = xorshift(rng_resp);
            dma_valid = 1'b0;
            repeat ((r[2:0] == 3'd0) ? 8 + r[6:3] : r[4:3]) begin
                @(posedge clk_w);
                #1;
            end
            dma_valid = 1'b1;
            dma_data  = ed_mem[addr][w];
            while (!dma_ready) begin
                @(posedge clk_w);
                #1;
            end
            @(posedge clk_w); // word taken at this edge
            #1;
        end
        dma_valid = 1'b0;
        served++;
    endtask

    task automatic pop_secondin(inout ohci_ed_pkg::ed_addr_t walk);
        ohci_ed_pkg::ed_addr_t exp_addr;
        exp_addr = ref_next_ed(walk);
        while (!pop_ready) begin
            @(posedge clk_w);
            #1;
        end
        repeat (xorshift(rng_pop) % 8) begin // slow consumer
            @(posedge clk_w);
            #1;
        end
        if (fi_valid) begin
            check_equal({4'h0, fi_w[3][31:4]}, {4'h0, ref_link}, "firstin next-ED link");
        end
        exp_q.push_back(exp_addr);
        pop = 1'b1;
        @(posedge clk_w);
        #1;
        pop = 1'b0;
        ref_link = ed_mem[exp_addr][3][31:4];
        walk = ref_link;
    endtask

    initial begin : responder
        ohci_ed_pkg::ed_addr_t addr;
        dma_valid = 1'b0;
        dma_data  = '0;
        forever begin
            @(posedge clk_w);
            #1;
            if (fetch_req) begin
                addr = fetch_addr;
                if (!ed_mem.exists(addr)) begin
                    abort_run("fetch request to an address outside the ED lists");
                end
                check_equal({4'h0, addr}, {4'h0, fetch_exp}, "fetch address");
                fetch_exp = ed_mem[addr][3][31:4]; // walker follows this link next
                serve_ed(addr);
                // fourth word taken at the last edge, flags up now
                check_equal(loaded, 1'b1, "secondin loaded after four words");
                check_equal(sec_empty, is_empty(addr), "secondin empty flag");
                check_equal(sec_valid, !is_empty(addr), "secondin valid flag");
            end
        end
    end

    // firstin holds the popped ed for the cycle after the pop
    initial begin : compare_pops
        logic pop_fire;
        ohci_ed_pkg::ed_addr_t exp_addr;
        pop_fire = 1'b0;
        forever begin
            @(posedge clk_w);
            #2;
            if (pop_fire) begin
                if (exp_q.size() == 0) begin
                    abort_run("pop accepted while no ED was expected");
                end
                exp_addr = exp_q.pop_front();
                for (int unsigned k = 0; k < 4; k++) begin
                    check_equal(fi_w[k], ed_mem[exp_addr][k], $sformatf("firstin dword%0d", k));
                end
                check_equal(fi_valid, 1'b1, "firstin valid after pop");
            end
            pop_fire = pop && pop_ready;
        end
    end

    initial begin : watchdog
        wait (lists_built);
        repeat ((n_np + n_p) * 200 + 500) @(posedge clk_w);
        abort_run("watchdog timeout, the DUT stopped making progress");
    end

    initial begin : main_seq
        ohci_ed_pkg::ed_addr_t walk;
        ohci_ed_pkg::ed_addr_t stash_addr;
        int unsigned np_fetched;
        int unsigned n_pops_a;
        int unsigned n_np_ne;
        pop  = 1'b0;
        np2p = 1'b0;
        p2np = 1'b0;
        n_np = 8 + xorshift(rng_build) % 5;
        n_p  = 3 + xorshift(rng_build) % 4;
        build_list(NpHead, n_np, 1'b1);
        build_list(PHead, n_p, 1'b0);
        n_np_ne  = count_nonempty(NpHead);
        n_pops_a = n_np_ne / 2;
        rng_resp = xorshift(rng_build);
        rng_pop  = xorshift(rng_build);
        lists_built = 1'b1;

        @(negedge reset_w);
        check_equal(fi_valid, 1'b0, "firstin valid after reset");
        check_equal(pop_ready, 1'b0, "pop ready after reset");
        check_equal(sec_valid, 1'b0, "secondin valid after reset");
        check_equal(fetch_req, 1'b0, "fetch request after reset");
        check_equal(dma_ready, 1'b1, "dma ready after reset");
        while (!fetch_req) begin
            @(posedge clk_w);
            #1;
        end
        check_equal({4'h0, fetch_addr}, {4'h0, NpHead}, "first fetch address");

        // nonperiodic list up to the ed that gets stashed
        walk = NpHead;
        for (int unsigned i = 0; i < n_pops_a; i++) pop_secondin(walk);
        stash_addr = ref_next_ed(walk);
        np_fetched = ref_visits;
        while (!sec_valid) begin
            @(posedge clk_w);
            #1;
        end
        np2p = 1'b1;
        fetch_exp = PHead; // detour starts at the periodic head
        @(posedge clk_w);
        #1;
        np2p = 1'b0;

        // whole periodic list, then back
        walk = PHead;
        for (int unsigned i = count_nonempty(PHead); i > 0; i--) pop_secondin(walk);
        while (served != np_fetched + n_p || loaded) begin
            @(posedge clk_w);
            #1;
        end
        p2np = 1'b1;
        fetch_exp = ed_mem[stash_addr][3][31:4]; // walk resumes behind the stashed ed
        @(posedge clk_w);
        #1;
        p2np = 1'b0;
        check_equal(pop_ready, 1'b1, "pop ready for the stashed ED");
        exp_q.push_back(stash_addr);
        pop = 1'b1;
        @(posedge clk_w);
        #1;
        pop = 1'b0;
        ref_link = ed_mem[stash_addr][3][31:4];
        walk = ref_link; // resume after the stashed ed

        for (int unsigned i = n_np_ne - n_pops_a - 1; i > 0; i--) pop_secondin(walk);
        while (exp_q.size() != 0) begin
            @(posedge clk_w);
            #1;
        end
        check_equal(served, n_np + n_p, "number of ED fetches");

        if (uut.i_queue.i_chk.err_count != 0) begin
            abort_run("queue assertions failed during the run");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

/* sim.f */
common/ohci_ed_pkg.sv
dma_queue/ed_register_chain.sv
dma_queue/ed_output_queue.sv
verilog/ed_list_walker.sv
verilog/ohci_ed_fetch_top.sv
sim/tb_clock_gen.sv
sim/ed_queue_chk.sv
sim/tb_ohci_ed_fetch.sv

/* Bender.yml */
package:
  name: ohci_ed_fetch

sources:
  # shared package first
  - common/ohci_ed_pkg.sv
  # rtl
  - dma_queue/ed_register_chain.sv
  - dma_queue/ed_output_queue.sv
  - verilog/ed_list_walker.sv
  - verilog/ohci_ed_fetch_top.sv
  # testbench
  - target: simulation
    files:
      - sim/tb_clock_gen.sv
      - sim/ed_queue_chk.sv
      - sim/tb_ohci_ed_fetch.sv
